//--- hw/crtc_cfg_if.sv
// Decoded timing configuration interface between register file and counters
`timescale 1ns/1ps
`default_nettype none

interface crtc_cfg_if;
    crtc_timing_pkg::count_t              h_total;      // Line length minus one
    crtc_timing_pkg::count_t              h_displayed;  // Visible characters
    crtc_timing_pkg::count_t              h_sync_pos;
    logic [4:0]                           h_sync_width; // 0 to 15 characters
    crtc_timing_pkg::count_t              v_total;      // Rows minus one
    logic [4:0]                           v_adjust;     // Extra lines after last row
    crtc_timing_pkg::count_t              v_displayed;
    crtc_timing_pkg::count_t              v_sync_pos;
    logic [4:0]                           v_sync_width; // 1 to 16 lines
    logic [crtc_timing_pkg::RA_W-1:0]     scan_lines;   // Lines per row minus one
    logic [crtc_timing_pkg::MA_W-1:0]     start_addr;

    modport regs (
        output h_total, h_displayed, h_sync_pos, h_sync_width,
        output v_total, v_adjust, v_displayed, v_sync_pos, v_sync_width,
        output scan_lines, start_addr
    );

    modport timing (
        input  h_total, h_displayed, h_sync_pos, h_sync_width,
        input  v_total, v_adjust, v_displayed, v_sync_pos, v_sync_width,
        input  scan_lines, start_addr
    );
endinterface

`default_nettype wire

//--- hw/crtc_raster_counter.sv
// Raster counter: scan line within a character row and the row start pulse
`timescale 1ns/1ps
`default_nettype none

module crtc_raster_counter (
    input  logic                             clk_i,
    input  logic                             reset_i,
    crtc_scan_if.raster                      scan,
    crtc_cfg_if.timing                       cfg,
    output logic [crtc_timing_pkg::RA_W-1:0] ra_o
);
    logic row_end;                                  // On last scan line of the row

    assign row_end        = ra_o >= cfg.scan_lines; // Also recovers from a shrunk R9
    assign scan.row_start = scan.line_start && row_end;

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            ra_o <= '0;
        end else if (scan.frame_start) begin
            ra_o <= '0;                             // Realign after adjust lines
        end else if (scan.line_start) begin
            ra_o <= row_end ? '0 : ra_o + 1'b1;
        end
    end
endmodule

`default_nettype wire

//--- hw/crtc_refresh_addr.sv
// Refresh address generator with row base latch and combined display enable
`timescale 1ns/1ps
`default_nettype none

module crtc_refresh_addr (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             cclk_en_i,
    crtc_scan_if.addr                        scan,
    crtc_cfg_if.timing                       cfg,
    output logic                             de_o,
    output logic [crtc_timing_pkg::MA_W-1:0] ma_o
);
    logic [crtc_timing_pkg::MA_W-1:0] row_base_q;   // First address of current row

    assign de_o = scan.h_de && scan.v_de;

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            ma_o       <= '0;
            row_base_q <= '0;
        end else if (cclk_en_i) begin
            if (scan.frame_start) begin
                row_base_q <= cfg.start_addr;       // Top of screen
                ma_o       <= cfg.start_addr;
            end else if (scan.row_start) begin
                row_base_q <= ma_o;                 // Next row follows last character
            end else if (scan.line_start) begin
                ma_o <= row_base_q;                 // Repeat row for each scan line
            end else if (de_o) begin
                ma_o <= ma_o + 1'b1;
            end
        end
    end

    // Address holds between character clocks
    a_ma_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        !cclk_en_i |=> $stable(ma_o));
endmodule

`default_nettype wire

//--- hw/crtc_reg_pkg.sv
// Register package: address type, register indices, reset defaults and status bit position
`default_nettype none

package crtc_reg_pkg;

    typedef logic [4:0] reg_addr_t;                 // Address register width

    localparam reg_addr_t R0_H_TOTAL     = 5'd0;    // Characters per line minus one
    localparam reg_addr_t R1_H_DISPLAYED = 5'd1;    // Displayed characters per line
    localparam reg_addr_t R2_H_SYNC_POS  = 5'd2;    // Character where hsync starts
    localparam reg_addr_t R3_SYNC_WIDTH  = 5'd3;    // [3:0] hsync chars, [7:4] vsync lines
    localparam reg_addr_t R4_V_TOTAL     = 5'd4;    // Rows per frame minus one
    localparam reg_addr_t R5_V_ADJUST    = 5'd5;    // Extra scan lines per frame
    localparam reg_addr_t R6_V_DISPLAYED = 5'd6;    // Displayed rows per frame
    localparam reg_addr_t R7_V_SYNC_POS  = 5'd7;    // Row where vsync starts
    localparam reg_addr_t R9_SCAN_LINE   = 5'd9;    // Scan lines per row minus one
    localparam reg_addr_t R12_START_HI   = 5'd12;   // Start address [13:8]
    localparam reg_addr_t R13_START_LO   = 5'd13;   // Start address [7:0]

    // Power-up contents of R13 down to R0, 40 column text screen
    localparam logic [13:0][7:0] REG_RESET = {
        8'h00, 8'h10,                               // R13, R12
        8'h00, 8'h00,                               // R11, R10 not used
        8'd7,  8'h00,                               // R9, R8 not used
        8'd28, 8'd25, 8'd5, 8'd32,                  // R7 to R4
        8'h01, 8'd48, 8'd40, 8'd63                  // R3 to R0
    };

    localparam int STATUS_VSYNC_BIT = 5;            // Vertical retrace flag in status byte

endpackage

`default_nettype wire

//--- hw/crtc_regfile.sv
// CRTC register file: address register, R0-R13 storage, status/register read, config decode
`timescale 1ns/1ps
`default_nettype none

module crtc_regfile (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       bus_stb_i,                   // One cycle transfer strobe
    input  logic       cs_i,
    input  logic       rw_ni,                       // Low for write
    input  logic       rs_i,                        // 0 address/status, 1 data register
    input  logic [7:0] data_i,
    input  logic       v_sync_i,
    output logic [7:0] data_o,
    crtc_cfg_if.regs   cfg
);
    crtc_reg_pkg::reg_addr_t addr_q;                // Selects R0..R13
    logic [13:0][7:0]        regs_q;
    logic                    wr_en;
    logic                    addr_ok;               // Address points at a real register
    logic [7:0]              status;

    assign wr_en   = bus_stb_i && cs_i && !rw_ni;
    assign addr_ok = addr_q <= crtc_reg_pkg::R13_START_LO;

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            addr_q <= '0;
            regs_q <= crtc_reg_pkg::REG_RESET;
        end else if (wr_en) begin
            if (!rs_i) begin
                addr_q <= data_i[4:0];              // Select register
            end else if (addr_ok) begin
                regs_q[addr_q[3:0]] <= data_i;      // Writes past R13 are dropped
            end
        end
    end

    always_comb begin
        status = '0;
        status[crtc_reg_pkg::STATUS_VSYNC_BIT] = v_sync_i;  // Retrace in progress
    end

    assign data_o = !rs_i ? status : (addr_ok ? regs_q[addr_q[3:0]] : 8'h00);

    // Timing fields straight from storage
    assign cfg.h_total     = regs_q[crtc_reg_pkg::R0_H_TOTAL[3:0]];
    assign cfg.h_displayed = regs_q[crtc_reg_pkg::R1_H_DISPLAYED[3:0]];
    assign cfg.h_sync_pos  = regs_q[crtc_reg_pkg::R2_H_SYNC_POS[3:0]];
    assign cfg.v_total     = regs_q[crtc_reg_pkg::R4_V_TOTAL[3:0]];
    assign cfg.v_adjust    = regs_q[crtc_reg_pkg::R5_V_ADJUST[3:0]][4:0];
    assign cfg.v_displayed = regs_q[crtc_reg_pkg::R6_V_DISPLAYED[3:0]];
    assign cfg.v_sync_pos  = regs_q[crtc_reg_pkg::R7_V_SYNC_POS[3:0]];
    assign cfg.scan_lines  = regs_q[crtc_reg_pkg::R9_SCAN_LINE[3:0]][4:0];
    assign cfg.start_addr  = {regs_q[crtc_reg_pkg::R12_START_HI[3:0]][5:0],
                              regs_q[crtc_reg_pkg::R13_START_LO[3:0]]};

    // R3 split, upper nibble of 0 means 16 lines
    assign cfg.h_sync_width = {1'b0, regs_q[crtc_reg_pkg::R3_SYNC_WIDTH[3:0]][3:0]};
    assign cfg.v_sync_width = (regs_q[crtc_reg_pkg::R3_SYNC_WIDTH[3:0]][7:4] == 4'd0)
                            ? 5'd16
                            : {1'b0, regs_q[crtc_reg_pkg::R3_SYNC_WIDTH[3:0]][7:4]};

    // Storage and address register only move on a qualified bus write
    a_no_stray_write: assert property (@(posedge clk_i) disable iff (reset_i)
        !wr_en |=> $stable(regs_q) && $stable(addr_q));
endmodule

`default_nettype wire

//--- hw/crtc_scan_if.sv
// Scan position interface: line, row and frame start pulses plus display enable halves
`timescale 1ns/1ps
`default_nettype none

interface crtc_scan_if;
    logic line_start;                               // From horizontal generator, on cclk_en
    logic row_start;                                // From raster counter, on line_start
    logic frame_start;                              // From vertical generator
    logic h_de;                                     // Horizontal display window
    logic v_de;                                     // Vertical display window

    // Frame start realigns the raster after the adjust lines
    modport raster (
        input  line_start, frame_start,
        output row_start
    );

    modport addr (
        input  line_start, row_start, frame_start, h_de, v_de
    );
endinterface

`default_nettype wire

//--- hw/crtc_sync_gen.sv
// Sync generator for one axis: total, display and sync counters plus vertical adjust lines
`timescale 1ns/1ps
`default_nettype none

module crtc_sync_gen #(
    parameter crtc_timing_pkg::axis_e AXIS = crtc_timing_pkg::AXIS_H
) (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        total_en_i,                 // Advances the character/row count
    input  logic        sync_en_i,                  // Advances sync width and adjust lines
    crtc_cfg_if.timing  cfg,
    output logic        sync_o,
    output logic        display_o,
    output logic        start_o                     // Line or frame start pulse
);
    localparam bit IS_V = (AXIS == crtc_timing_pkg::AXIS_V);

    crtc_timing_pkg::count_t total;
    crtc_timing_pkg::count_t displayed;
    crtc_timing_pkg::count_t sync_pos;
    crtc_timing_pkg::count_t cnt_q;
    crtc_timing_pkg::count_t cnt_d;
    logic [4:0]              width;
    logic [4:0]              adjust;
    logic [4:0]              sync_cnt_q;            // Sync units elapsed
    logic [4:0]              adj_cnt_q;             // Adjust lines elapsed
    logic                    adj_q;                 // In adjust lines after last row
    logic                    last;
    logic                    wrap;
    logic                    enter_adj;
    logic                    start;
    logic                    tick;                  // Count moved this cycle
    logic                    display_d;
    logic                    sync_d;

    assign total     = IS_V ? cfg.v_total      : cfg.h_total;
    assign displayed = IS_V ? cfg.v_displayed  : cfg.h_displayed;
    assign sync_pos  = IS_V ? cfg.v_sync_pos   : cfg.h_sync_pos;
    assign width     = IS_V ? cfg.v_sync_width : cfg.h_sync_width;
    assign adjust    = IS_V ? cfg.v_adjust     : 5'd0;  // No adjust horizontally

    assign last      = cnt_q == total;
    assign wrap      = last && total_en_i && !adj_q;
    assign enter_adj = wrap && (adjust != 5'd0);
    assign start     = adj_q ? (sync_en_i && adj_cnt_q == adjust) : (wrap && adjust == 5'd0);
    assign tick      = start || (total_en_i && !last && !adj_q);
    assign start_o   = start;

    assign cnt_d     = start ? '0 : (tick ? cnt_q + 1'b1 : cnt_q);
    assign display_d = (cnt_d == displayed) ? 1'b0 : (start ? 1'b1 : display_o);
    // Sync only fires as the count steps onto the position, not on every line of that row
    assign sync_d    = (sync_cnt_q >= width) ? 1'b0
                     : ((tick && cnt_d == sync_pos) ? 1'b1 : sync_o);

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            cnt_q      <= '0;
            display_o  <= 1'b0;
            sync_o     <= 1'b0;
            sync_cnt_q <= '0;
            adj_q      <= 1'b0;
            adj_cnt_q  <= '0;
        end else begin
            if (total_en_i || start) begin
                cnt_q     <= cnt_d;
                display_o <= display_d;
            end
            if (sync_en_i) begin
                sync_o     <= sync_d;
                sync_cnt_q <= sync_d ? sync_cnt_q + 1'b1 : '0;
                if (start) begin
                    adj_q     <= 1'b0;
                    adj_cnt_q <= '0;
                end else if (enter_adj) begin
                    adj_q     <= 1'b1;
                    adj_cnt_q <= 5'd1;              // First adjust line already running
                end else if (adj_q) begin
                    adj_cnt_q <= adj_cnt_q + 1'b1;
                end
            end
        end
    end

    // Width counter stays within the width seen on the enabling cycle
    a_sync_width: assert property (@(posedge clk_i) disable iff (reset_i)
        sync_en_i |=> sync_cnt_q <= $past(width));
endmodule

`default_nettype wire

//--- hw/crtc_timing_pkg.sv
// Timing package: axis selector, counter type and refresh/raster address widths
`default_nettype none

package crtc_timing_pkg;

    typedef enum logic {
        AXIS_H,                                     // Counts characters within a line
        AXIS_V                                      // Counts rows, sync and adjust in lines
    } axis_e;

    localparam int MA_W = 14;                       // Refresh memory address width
    localparam int RA_W = 5;                        // Raster address width

    typedef logic [7:0] count_t;                    // Character or row counter

endpackage

`default_nettype wire

//--- hw/crtc_top.sv
// CRTC top level: register file, horizontal and vertical sync, raster and refresh address
`timescale 1ns/1ps
`default_nettype none

module crtc_top (
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             cclk_en_i,  // Character clock strobe
    input  logic                             bus_stb_i,
    input  logic                             cs_i,
    input  logic                             rw_ni,
    input  logic                             rs_i,
    input  logic [7:0]                       data_i,
    output logic [7:0]                       data_o,
    output logic                             data_oe_o,  // CPU read in progress
    output logic                             h_sync_o,
    output logic                             v_sync_o,
    output logic                             de_o,
    output logic [crtc_timing_pkg::MA_W-1:0] ma_o,
    output logic [crtc_timing_pkg::RA_W-1:0] ra_o
);
    crtc_cfg_if  cfg ();
    crtc_scan_if scan ();

    assign data_oe_o = cs_i && rw_ni;

    crtc_regfile u_regfile (
        .clk_i(clk_i), .reset_i(reset_i), .bus_stb_i(bus_stb_i), .cs_i(cs_i),
        .rw_ni(rw_ni), .rs_i(rs_i), .data_i(data_i), .v_sync_i(v_sync_o),
        .data_o(data_o), .cfg(cfg)
    );

    crtc_sync_gen #(.AXIS(crtc_timing_pkg::AXIS_H)) u_h_sync (
        .clk_i(clk_i), .reset_i(reset_i),
        .total_en_i(cclk_en_i),                     // One count per character
        .sync_en_i(cclk_en_i),
        .cfg(cfg), .sync_o(h_sync_o), .display_o(scan.h_de), .start_o(scan.line_start)
    );

    crtc_raster_counter u_raster (
        .clk_i(clk_i), .reset_i(reset_i), .scan(scan), .cfg(cfg), .ra_o(ra_o)
    );

    crtc_sync_gen #(.AXIS(crtc_timing_pkg::AXIS_V)) u_v_sync (
        .clk_i(clk_i), .reset_i(reset_i),
        .total_en_i(scan.row_start),                // Rows
        .sync_en_i(scan.line_start),                // Sync width and adjust in lines
        .cfg(cfg), .sync_o(v_sync_o), .display_o(scan.v_de), .start_o(scan.frame_start)
    );

    crtc_refresh_addr u_refresh (
        .clk_i(clk_i), .reset_i(reset_i), .cclk_en_i(cclk_en_i),
        .scan(scan), .cfg(cfg), .de_o(de_o), .ma_o(ma_o)
    );
endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the CRTC testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module crtc_tb -Mdir obj_dir -o crtc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/crtc_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

//--- tb.f
hw/crtc_timing_pkg.sv
hw/crtc_reg_pkg.sv
hw/crtc_cfg_if.sv
hw/crtc_scan_if.sv
hw/crtc_regfile.sv
hw/crtc_sync_gen.sv
hw/crtc_raster_counter.sv
hw/crtc_refresh_addr.sv
hw/crtc_top.sv
verif/crtc_tb.sv

//--- verif/crtc_tb.sv
// CRTC testbench: reset defaults, register access and per-configuration frame timing checks
`timescale 1ns/1ps
`default_nettype none

module crtc_tb;
    localparam int NUM_CFG = 3;
    localparam int TIMEOUT = 200000;                // Cycles allowed per wait

    logic        clk_i, reset_i, cclk_en_i, bus_stb_i, cs_i, rw_ni, rs_i;
    logic [7:0]  data_i, data_o;
    logic        data_oe_o, h_sync_o, v_sync_o, de_o;
    logic [13:0] ma_o;
    logic [4:0]  ra_o;

    // Cols: h_total h_disp h_sync_pos R3 v_total v_adj v_disp v_sync_pos scan_lines start
    // then expected frame lines and vsync lines
    int cfg_tab [NUM_CFG][12] = '{
        '{11, 8, 9, 'h22, 5, 2, 3, 4, 2, 'h123, 20, 2},
        '{9, 5, 6, 'h03, 9, 0, 2, 3, 1, 'h3FFE, 20, 16},   // Vsync field 0, address wrap
        '{15, 12, 13, 'h41, 3, 5, 2, 2, 3, 'h0A0, 21, 4}   // Adjust longer than a row
    };
    int def_idx [11] = '{0, 1, 2, 3, 4, 5, 6, 7, 9, 12, 13};
    int def_val [11] = '{63, 40, 48, 1, 32, 5, 25, 28, 7, 16, 0};
    string test_name;
    int checks = 0;
    int errors = 0;
    int tests  = 0;

    crtc_top dut_i (
        .clk_i(clk_i), .reset_i(reset_i), .cclk_en_i(cclk_en_i), .bus_stb_i(bus_stb_i),
        .cs_i(cs_i), .rw_ni(rw_ni), .rs_i(rs_i), .data_i(data_i), .data_o(data_o),
        .data_oe_o(data_oe_o), .h_sync_o(h_sync_o), .v_sync_o(v_sync_o), .de_o(de_o),
        .ma_o(ma_o), .ra_o(ra_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;                  // 10 ns period
    end

    initial begin
        int unsigned rnd;
        cclk_en_i = 1'b0;
        rnd = $urandom(26968);                      // Seed once
        forever begin
            @(posedge clk_i);
            rnd = $urandom;
            cclk_en_i <= rnd[0];                    // Character strobe about half the cycles
        end
    end

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, expected,
                     actual);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s: %s never arrived", test_name, what);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic bus_write(input bit sel, input int value);
        @(posedge clk_i);
        bus_stb_i <= 1'b1;
        cs_i      <= 1'b1;
        rw_ni     <= 1'b0;
        rs_i      <= sel;
        data_i    <= value[7:0];
        @(negedge clk_i);
        check_value("data_oe_o during write", 0, int'(data_oe_o));
        @(posedge clk_i);                           // Strobe taken on this edge
        bus_stb_i <= 1'b0;
        cs_i      <= 1'b0;
        rw_ni     <= 1'b1;
    endtask

    task automatic bus_read(input bit sel, output int value, output int vs);
        @(posedge clk_i);
        cs_i  <= 1'b1;
        rw_ni <= 1'b1;
        rs_i  <= sel;
        @(negedge clk_i);
        value = int'(data_o);                       // Combinational read data
        vs    = int'(v_sync_o);
        check_value("data_oe_o during read", 1, int'(data_oe_o));
        @(posedge clk_i);
        cs_i <= 1'b0;
        @(negedge clk_i);
        check_value("data_oe_o when idle", 0, int'(data_oe_o));
    endtask

    task automatic write_reg(input int idx, input int value);
        int rd;
        int vs;
        bus_write(1'b0, idx);                       // Address register
        bus_write(1'b1, value);
        bus_read(1'b1, rd, vs);
        check_value($sformatf("R%0d read-back", idx), value, rd);
    endtask

    task automatic check_defaults();
        int rd;
        int vs;
        for (int k = 0; k < 11; k++) begin
            bus_write(1'b0, def_idx[k]);
            bus_read(1'b1, rd, vs);
            check_value($sformatf("R%0d default", def_idx[k]), def_val[k], rd);
        end
    endtask

    task automatic program_entry(input int e);
        int st;
        int vs;
        for (int k = 0; k < 9; k++) begin
            write_reg((k < 8) ? k : 9, cfg_tab[e][k]); // R8 skipped
        end
        write_reg(12, cfg_tab[e][9] >> 8);
        write_reg(13, cfg_tab[e][9] & 255);
        bus_read(1'b0, st, vs);
        check_value("status byte", vs * 32, st);    // Only bit 5 may be set
    endtask

    task automatic measure_frame(input int e);
        int cyc, en_cnt, lines, vs_lines, de_lines, h_at, de_at, hp, hh, dr, rows;
        int st;
        int vs;
        bit en_next, pv, ph, pd, done;
        rows = cfg_tab[e][8] + 1;
        @(negedge clk_i);
        pv   = v_sync_o;
        cyc  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk_i);
            cyc++;
            if (cyc > TIMEOUT) report_timeout("v_sync_o rise");
            done = v_sync_o && !pv;
            pv   = v_sync_o;
        end
        ph = h_sync_o;
        pd = de_o;
        en_next = cclk_en_i;                        // Used by the next rising edge
        {en_cnt, lines, vs_lines, de_lines, cyc} = '0;
        {h_at, de_at, hp, hh, dr} = {5{-32'sd1}};   // Not seen yet
        done = 1'b0;
        while (!done) begin
            @(negedge clk_i);
            cyc++;
            if (cyc > TIMEOUT) report_timeout("next v_sync_o rise");
            if (en_next) en_cnt++;
            en_next = cclk_en_i;
            if (h_sync_o && !ph) begin              // One hsync per line
                lines++;
                if (v_sync_o) vs_lines++;
                if (h_at >= 0 && hp < 0) hp = en_cnt - h_at;
                h_at = en_cnt;
            end
            if (!h_sync_o && ph && h_at >= 0 && hh < 0) hh = en_cnt - h_at;
            if (de_o && !pd) begin                  // First character of a displayed line
                check_value("ra_o at line start", de_lines % rows, int'(ra_o));
                check_value("ma_o at line start",
                            (cfg_tab[e][9] + (de_lines / rows) * cfg_tab[e][1]) % 16384,
                            int'(ma_o));
                de_lines++;
                de_at = en_cnt;
            end
            if (!de_o && pd && de_at >= 0 && dr < 0) dr = en_cnt - de_at;
            done = v_sync_o && !pv;
            pv = v_sync_o;
            ph = h_sync_o;
            pd = de_o;
        end
        bus_read(1'b0, st, vs);                     // Vsync just rose and lasts a line or more
        check_value("status during vsync", 32, st);
        check_value("frame lines", cfg_tab[e][10], lines);
        check_value("vsync lines", cfg_tab[e][11], vs_lines);
        check_value("displayed lines", cfg_tab[e][6] * rows, de_lines);
        check_value("hsync period", cfg_tab[e][0] + 1, hp);
        check_value("hsync width", cfg_tab[e][3] & 15, hh);
        check_value("de run", cfg_tab[e][1], dr);
    endtask

    task automatic finish_test(input int c0, input int e0);
        tests++;
        $display("%s done: %0d checks, %0d errors", test_name, checks - c0, errors - e0);
    endtask

    initial begin
        int c0;
        int e0;
        reset_i   = 1'b1;
        bus_stb_i = 1'b0;
        cs_i      = 1'b0;
        rw_ni     = 1'b1;
        rs_i      = 1'b0;
        data_i    = 8'h00;
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;
        for (int pass = 0; pass < 2; pass++) begin
            if (pass == 1) begin                    // Reset in the middle of the run
                @(posedge clk_i);
                reset_i <= 1'b1;
                repeat (3) @(posedge clk_i);
                reset_i <= 1'b0;
            end
            test_name = $sformatf("defaults_p%0d", pass);
            c0 = checks;
            e0 = errors;
            check_defaults();
            finish_test(c0, e0);
            for (int e = 0; e < NUM_CFG; e++) begin
                test_name = $sformatf("cfg%0d_p%0d", e, pass);
                c0 = checks;
                e0 = errors;
                program_entry(e);
                measure_frame(e);
                finish_test(c0, e0);
            end
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire
